/* rtl/sdmac_regs_pkg.sv */
/*
  CPU-visible register map of the SCSI DMA controller.
  Offsets are word offsets on address bits [6:2]. The control
  register is a union that is stored raw and decoded as fields.
*/
package sdmac_regs_pkg;

    // Word offsets on addr[6:2]
    localparam logic [4:0] REG_WTC    = 5'h01;
    localparam logic [4:0] REG_CNTR   = 5'h02;
    localparam logic [4:0] REG_ST_DMA = 5'h04;
    localparam logic [4:0] REG_CINT   = 5'h06;
    localparam logic [4:0] REG_ISTR   = 5'h07;
    localparam logic [4:0] REG_SP_DMA = 5'h0f;
    localparam logic [4:0] REG_FIFO   = 5'h10;

    // Transfer count width
    localparam int WTC_BITS = 24;

    // Bit positions in the ISTR word
    localparam int ISTR_FF   = 0;
    localparam int ISTR_FE   = 1;
    localparam int ISTR_DONE = 2;
    localparam int ISTR_INT  = 4;

    // Control register, raw longword or field view
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            // Reserved, kept as written
            logic [28:0] rsvd_hi;
            // Interrupt enable
            logic        intena;
            // 1 = port to memory
            logic        dir;
            logic        rsvd_lo;
        } f;
    } cntr_u;

endpackage

/* rtl/sdmac_port_pkg.sv */
/*
  Port-side timing and FIFO geometry of the SCSI DMA controller.
  Shared by the port sequencer and the byte/longword FIFO.
*/
package sdmac_port_pkg;

    // Clocks that DACK and the strobe stay high
    localparam int IO_CYCLES   = 3;
    localparam int IO_CNT_BITS = 2;
    localparam logic [IO_CNT_BITS-1:0] IO_LAST = IO_CNT_BITS'(IO_CYCLES - 1);

    // Port sequencer state encoding
    localparam logic [1:0] PS_IDLE    = 2'd0;
    localparam logic [1:0] PS_STROBE  = 2'd1;
    localparam logic [1:0] PS_RECOVER = 2'd2;

    // FIFO depth in longwords
    localparam int FIFO_WORDS    = 4;
    localparam int FIFO_PTR_BITS = 2;
    localparam logic [FIFO_PTR_BITS:0] FIFO_CNT_FULL = (FIFO_PTR_BITS + 1)'(FIFO_WORDS);

endpackage

/* rtl/sdmac_registers.sv */
/*
  CPU register block: decodes single-cycle accesses, acknowledges
  them one clock later, and owns the control register, the transfer
  counter, DMA state, the done flag and the interrupt output.
*/
`timescale 1ns/1ns

module sdmac_registers (
    input  logic        sclk_i,
    input  logic        rst_i,
    input  logic        cs_i,
    input  logic        as_i,
    input  logic        rw_i,
    input  logic [4:0]  addr_i,
    input  logic [31:0] data_i,
    output logic [31:0] data_o,
    output logic        dsack_o,
    input  logic        byte_push_i,
    input  logic        byte_pop_i,
    input  logic        fifo_full_i,
    input  logic        fifo_empty_i,
    input  logic [31:0] fifo_word_i,
    output logic        dma_active_o,
    output logic        dir_o,
    output logic        word_push_o,
    output logic        word_pop_o,
    output logic [31:0] word_o,
    output logic        fifo_clear_o,
    output logic        fifo_flush_o,
    output logic        int_o
);

    sdmac_regs_pkg::cntr_u cntr_q;
    logic [sdmac_regs_pkg::WTC_BITS-1:0] wtc_q;
    logic        done_q;
    logic        acc, wr, rd;
    logic        xfer;
    logic [31:0] istr;

    // One-cycle access qualified by chip select
    assign acc = cs_i && as_i;
    assign wr  = acc && !rw_i;
    assign rd  = acc && rw_i;

    // CPU side of the FIFO register
    assign word_push_o  = wr && (addr_i == sdmac_regs_pkg::REG_FIFO);
    assign word_pop_o   = rd && (addr_i == sdmac_regs_pkg::REG_FIFO);
    assign word_o       = data_i;
    // Start of DMA empties the FIFO
    assign fifo_clear_o = wr && (addr_i == sdmac_regs_pkg::REG_ST_DMA);

    // Any port byte counts down
    assign xfer  = (byte_push_i || byte_pop_i) && dma_active_o;
    assign dir_o = cntr_q.f.dir;
    assign int_o = done_q && cntr_q.f.intena;

    // Status word
    always_comb begin
        istr = '0;
        istr[sdmac_regs_pkg::ISTR_FF]   = fifo_full_i;
        istr[sdmac_regs_pkg::ISTR_FE]   = fifo_empty_i;
        istr[sdmac_regs_pkg::ISTR_DONE] = done_q;
        istr[sdmac_regs_pkg::ISTR_INT]  = int_o;
    end

    always_ff @(posedge sclk_i) begin
        if (rst_i) begin
            dsack_o      <= 1'b0;
            cntr_q.raw   <= '0;
            wtc_q        <= '0;
            dma_active_o <= 1'b0;
            done_q       <= 1'b0;
            fifo_flush_o <= 1'b0;
        end else begin
            dsack_o      <= acc;
            fifo_flush_o <= 1'b0;
            if (wr && addr_i == sdmac_regs_pkg::REG_CNTR)
                cntr_q.raw <= data_i;
            // CPU load wins over a count pulse
            if (wr && addr_i == sdmac_regs_pkg::REG_WTC) begin
                wtc_q <= data_i[sdmac_regs_pkg::WTC_BITS-1:0];
            end else if (xfer && wtc_q != '0) begin
                wtc_q <= wtc_q - 1'b1;
                // Last byte ends the DMA
                if (wtc_q == 1) begin
                    dma_active_o <= 1'b0;
                    done_q       <= 1'b1;
                    fifo_flush_o <= cntr_q.f.dir;
                end
            end
            if (fifo_clear_o) begin
                dma_active_o <= 1'b1;
                done_q       <= 1'b0;
            end
            // Stop without done
            if (wr && addr_i == sdmac_regs_pkg::REG_SP_DMA)
                dma_active_o <= 1'b0;
            if (wr && addr_i == sdmac_regs_pkg::REG_CINT)
                done_q <= 1'b0;
        end
    end

    // Read data, valid during the dsack pulse
    always_ff @(posedge sclk_i) begin
        if (rd) begin
            case (addr_i)
                sdmac_regs_pkg::REG_CNTR: data_o <= cntr_q.raw;
                sdmac_regs_pkg::REG_WTC:  data_o <= 32'(wtc_q);
                sdmac_regs_pkg::REG_ISTR: data_o <= istr;
                sdmac_regs_pkg::REG_FIFO: data_o <= fifo_word_i;
                default:                  data_o <= '0;
            endcase
        end
    end

endmodule

/* rtl/scsi_port_sm.sv */
/*
  Peripheral port sequencer. Answers DREQ from the SCSI chip with
  a DACK plus IOR or IOW strobe held for IO_CYCLES clocks, moves
  one byte per cycle and recovers for one clock afterwards.
*/
`timescale 1ns/1ns

module scsi_port_sm (
    input  logic       sclk_i,
    input  logic       rst_i,
    input  logic       dma_active_i,
    input  logic       dir_i,
    input  logic       fifo_full_i,
    input  logic       fifo_empty_i,
    input  logic       dreq_i,
    input  logic [7:0] pd_i,
    input  logic [7:0] fifo_byte_i,
    output logic       dack_o,
    output logic       ior_o,
    output logic       iow_o,
    output logic [7:0] pd_o,
    output logic       byte_push_o,
    output logic       byte_pop_o,
    output logic [7:0] byte_o
);

    logic [1:0] state;
    logic [sdmac_port_pkg::IO_CNT_BITS-1:0] cyc_cnt;
    // Direction frozen for the whole byte cycle
    logic dir_q;
    logic can_start;
    logic last_cyc;

    // Read needs a free slot, write needs a byte
    assign can_start = dreq_i && dma_active_i
                     && (dir_i ? !fifo_full_i : !fifo_empty_i);

    assign last_cyc = (state == sdmac_port_pkg::PS_STROBE)
                    && (cyc_cnt == sdmac_port_pkg::IO_LAST);

    // Strobes decoded from state
    assign dack_o = (state == sdmac_port_pkg::PS_STROBE);
    assign ior_o  = dack_o && dir_q;
    assign iow_o  = dack_o && !dir_q;

    // Byte handoff on the last strobe clock
    assign byte_push_o = last_cyc && dir_q;
    assign byte_pop_o  = last_cyc && !dir_q;
    // Read byte sampled by the FIFO at the end of the strobe
    assign byte_o      = pd_i;

    always_ff @(posedge sclk_i) begin
        if (rst_i) begin
            state   <= sdmac_port_pkg::PS_IDLE;
            cyc_cnt <= '0;
            dir_q   <= 1'b0;
        end else begin
            case (state)
                sdmac_port_pkg::PS_IDLE: begin
                    if (can_start) begin
                        state   <= sdmac_port_pkg::PS_STROBE;
                        cyc_cnt <= '0;
                        dir_q   <= dir_i;
                    end
                end
                sdmac_port_pkg::PS_STROBE: begin
                    if (last_cyc)
                        state <= sdmac_port_pkg::PS_RECOVER;
                    else
                        cyc_cnt <= cyc_cnt + 1'b1;
                end
                // One dead clock before sampling DREQ again
                sdmac_port_pkg::PS_RECOVER: state <= sdmac_port_pkg::PS_IDLE;
                default:                    state <= sdmac_port_pkg::PS_IDLE;
            endcase
        end
    end

    // Write byte held for the whole strobe
    always_ff @(posedge sclk_i) begin
        if (state == sdmac_port_pkg::PS_IDLE && can_start && !dir_i)
            pd_o <= fifo_byte_i;
    end

endmodule

/* rtl/dma_fifo.sv */
/*
  Longword FIFO between the CPU and the port. The byte side packs
  and unpacks longwords most significant byte first; the longword
  side is the CPU FIFO register. Flush commits a zero-padded part.
*/
`timescale 1ns/1ns

module dma_fifo (
    input  logic        sclk_i,
    input  logic        rst_i,
    input  logic        clear_i,
    input  logic        flush_i,
    input  logic        byte_push_i,
    input  logic [7:0]  byte_i,
    input  logic        byte_pop_i,
    output logic [7:0]  byte_o,
    input  logic        word_push_i,
    input  logic [31:0] word_i,
    input  logic        word_pop_i,
    output logic [31:0] word_o,
    output logic        full_o,
    output logic        empty_o
);

    logic [31:0] mem [sdmac_port_pkg::FIFO_WORDS];
    logic [sdmac_port_pkg::FIFO_PTR_BITS-1:0] wr_ptr, rd_ptr;
    logic [sdmac_port_pkg::FIFO_PTR_BITS:0]   count;
    // Byte lane indices, 0 = bits 31:24
    logic [1:0]  in_lane, out_lane;
    logic [31:0] pack_q, pack_next;
    logic        byte_commit, flush_commit;
    logic        do_push, do_pop;
    logic [31:0] push_data;

    assign full_o  = (count == sdmac_port_pkg::FIFO_CNT_FULL);
    assign empty_o = (count == '0);

    // Incoming byte merged into the packing word
    always_comb begin
        pack_next = pack_q;
        if (byte_push_i)
            pack_next[{~in_lane, 3'b000} +: 8] = byte_i;
    end

    assign byte_commit  = byte_push_i && (in_lane == 2'd3);
    // Unused lanes are still zero
    assign flush_commit = flush_i && (in_lane != 2'd0);
    assign do_push      = (byte_commit || flush_commit || word_push_i) && !full_o;
    assign push_data    = (byte_commit || flush_commit) ? pack_next : word_i;
    assign do_pop       = (word_pop_i || (byte_pop_i && out_lane == 2'd3)) && !empty_o;

    // Empty pop reads as zero
    assign word_o = empty_o ? '0 : mem[rd_ptr];
    assign byte_o = mem[rd_ptr][{~out_lane, 3'b000} +: 8];

    always_ff @(posedge sclk_i) begin
        if (do_push && !clear_i)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge sclk_i) begin
        if (rst_i || clear_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            in_lane  <= '0;
            out_lane <= '0;
            pack_q   <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Packing side
            if (flush_commit) begin
                pack_q  <= '0;
                in_lane <= '0;
            end else if (byte_push_i) begin
                in_lane <= in_lane + 1'b1;
                pack_q  <= byte_commit ? '0 : pack_next;
            end
            // Unpacking side
            if (byte_pop_i && !empty_o)
                out_lane <= out_lane + 1'b1;
        end
    end

endmodule

/* rtl/resdmac.sv */
/*
  Top level of the SCSI DMA controller. Joins the CPU register
  block, the port sequencer and the byte/longword FIFO.
*/
`timescale 1ns/1ns

module resdmac (
    input  logic        sclk_i,
    input  logic        rst_i,
    input  logic        cs_i,
    input  logic        as_i,
    input  logic        rw_i,
    input  logic [6:2]  addr_i,
    input  logic [31:0] data_i,
    output logic [31:0] data_o,
    output logic        dsack_o,
    input  logic        dreq_i,
    input  logic [7:0]  pd_i,
    output logic [7:0]  pd_o,
    output logic        dack_o,
    output logic        ior_o,
    output logic        iow_o,
    output logic        int_o
);

    // Register block to port and FIFO
    logic        dma_active, dir;
    logic        word_push, word_pop;
    logic [31:0] word_wdata, word_rdata;
    logic        fifo_clear, fifo_flush;
    // Port side byte traffic
    logic        byte_push, byte_pop;
    logic [7:0]  byte_wdata, byte_rdata;
    logic        fifo_full, fifo_empty;

    sdmac_registers u_regs (
        .sclk_i(sclk_i), .rst_i(rst_i),
        .cs_i(cs_i), .as_i(as_i), .rw_i(rw_i), .addr_i(addr_i), .data_i(data_i),
        .data_o(data_o), .dsack_o(dsack_o),
        .byte_push_i(byte_push), .byte_pop_i(byte_pop),
        .fifo_full_i(fifo_full), .fifo_empty_i(fifo_empty), .fifo_word_i(word_rdata),
        .dma_active_o(dma_active), .dir_o(dir),
        .word_push_o(word_push), .word_pop_o(word_pop), .word_o(word_wdata),
        .fifo_clear_o(fifo_clear), .fifo_flush_o(fifo_flush),
        .int_o(int_o)
    );

    scsi_port_sm u_port (
        .sclk_i(sclk_i), .rst_i(rst_i),
        .dma_active_i(dma_active), .dir_i(dir),
        .fifo_full_i(fifo_full), .fifo_empty_i(fifo_empty),
        .dreq_i(dreq_i), .pd_i(pd_i), .fifo_byte_i(byte_rdata),
        .dack_o(dack_o), .ior_o(ior_o), .iow_o(iow_o), .pd_o(pd_o),
        .byte_push_o(byte_push), .byte_pop_o(byte_pop), .byte_o(byte_wdata)
    );

    dma_fifo u_fifo (
        .sclk_i(sclk_i), .rst_i(rst_i),
        .clear_i(fifo_clear), .flush_i(fifo_flush),
        .byte_push_i(byte_push), .byte_i(byte_wdata),
        .byte_pop_i(byte_pop), .byte_o(byte_rdata),
        .word_push_i(word_push), .word_i(word_wdata),
        .word_pop_i(word_pop), .word_o(word_rdata),
        .full_o(fifo_full), .empty_o(fifo_empty)
    );

endmodule

/* tb/resdmac_asserts.sv */
/*
  Concurrent checks on the port strobes, the CPU acknowledge and
  the FIFO limits. Bound into every resdmac instance.
*/
`timescale 1ns/1ns

module resdmac_asserts (
    input logic sclk_i,
    input logic rst_i,
    input logic dack_i,
    input logic ior_i,
    input logic dsack_i,
    input logic byte_push_i,
    input logic fifo_full_i
);

    // DACK held for exactly the strobe length
    a_dack_len: assert property (@(posedge sclk_i) disable iff (rst_i)
        $fell(dack_i) |-> $past(dack_i, sdmac_port_pkg::IO_CYCLES)
            && !$past(dack_i, sdmac_port_pkg::IO_CYCLES + 1))
        else $error("dack not held for the strobe length");

    // Read byte taken in the last IOR clock
    a_push_last: assert property (@(posedge sclk_i) disable iff (rst_i)
        byte_push_i |-> ior_i && $past(ior_i, sdmac_port_pkg::IO_CYCLES - 1))
        else $error("byte pushed outside the last read strobe clock");

    // Acknowledge is a single pulse
    a_dsack_pulse: assert property (@(posedge sclk_i) disable iff (rst_i)
        dsack_i |=> !dsack_i) else $error("dsack high for two cycles");

    a_no_push_full: assert property (@(posedge sclk_i) disable iff (rst_i)
        !(byte_push_i && fifo_full_i)) else $error("byte pushed into a full FIFO");

endmodule

bind resdmac resdmac_asserts u_asserts (
    .sclk_i(sclk_i), .rst_i(rst_i), .dack_i(dack_o), .ior_i(ior_o),
    .dsack_i(dsack_o), .byte_push_i(byte_push), .fifo_full_i(fifo_full)
);

/* tb/resdmac_tb.sv */
/*
  Testbench for the SCSI DMA controller. Models the CPU bus and
  the SCSI chip, and checks register readback, read and write DMA,
  FIFO back-pressure and the interrupt against a packing model.
*/
`timescale 1ns/1ns

module resdmac_tb;

    // Bytes moved over all tests
    localparam int TEST_BYTES  = 46;
    localparam int WATCHDOG_NS = TEST_BYTES * 5 * 8 * 2 + 2000;

    logic        sclk_i = 1'b0;
    logic        rst_i, cs_i, as_i, rw_i;
    logic [4:0]  addr_i;
    logic [31:0] data_i, data_o;
    logic        dsack_o, dack_o, ior_o, iow_o, int_o;
    logic        dreq_i = 1'b0;
    logic [7:0]  pd_i = 8'h00;
    logic [7:0]  pd_o;

    // SCSI chip model state
    int          chip_count = 0;
    int          strobes = 0;
    logic        strobe_q = 1'b0;
    logic        iow_prev = 1'b0;
    logic [31:0] xs = 32'h3462_ce07;
    logic [7:0]  sent_bytes[$];
    logic [7:0]  exp_bytes[$];
    int          captured = 0;
    logic        watch_int = 1'b0;

    resdmac dut (
        .sclk_i(sclk_i), .rst_i(rst_i), .cs_i(cs_i), .as_i(as_i), .rw_i(rw_i),
        .addr_i(addr_i), .data_i(data_i), .data_o(data_o), .dsack_o(dsack_o),
        .dreq_i(dreq_i), .pd_i(pd_i), .pd_o(pd_o), .dack_o(dack_o),
        .ior_o(ior_o), .iow_o(iow_o), .int_o(int_o)
    );

    always #4 sclk_i = ~sclk_i;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Bytes to longwords, MSB first, last one zero padded
    function automatic void pack_ref(input logic [7:0] b[$], output logic [31:0] w[$]);
        logic [31:0] acc;
        w.delete();
        acc = '0;
        for (int i = 0; i < b.size(); i++) begin
            acc[31 - 8 * (i % 4) -: 8] = b[i];
            if (i % 4 == 3) begin
                w.push_back(acc);
                acc = '0;
            end
        end
        if (b.size() % 4 != 0)
            w.push_back(acc);
    endfunction

    task automatic fail(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
            fail($sformatf("error %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    task automatic check_cntr(input sdmac_regs_pkg::cntr_u got,
                              input sdmac_regs_pkg::cntr_u exp, input string what);
        if (got.raw !== exp.raw || got.f.dir !== exp.f.dir || got.f.intena !== exp.f.intena)
            fail($sformatf("error %0t: %s got %h expected %h", $time, what, got.raw, exp.raw));
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp)
            fail($sformatf("error %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    // One access cycle, then wait for the acknowledge
    task automatic cpu_access(input logic rw, input logic [4:0] a, input logic [31:0] d,
                              output logic [31:0] q);
        int n;
        @(posedge sclk_i);
        #1;
        cs_i = 1'b1;
        as_i = 1'b1;
        rw_i = rw;
        addr_i = a;
        data_i = d;
        @(posedge sclk_i);
        #1;
        cs_i = 1'b0;
        as_i = 1'b0;
        rw_i = 1'b1;
        n = 0;
        while (!dsack_o && n < 8) begin
            @(posedge sclk_i);
            #1;
            n++;
        end
        if (!dsack_o)
            fail("CPU access was never acknowledged");
        q = data_o;
    endtask

    task automatic cpu_write(input logic [4:0] a, input logic [31:0] d);
        logic [31:0] unused;
        cpu_access(1'b0, a, d, unused);
    endtask

    task automatic cpu_read(input logic [4:0] a, output logic [31:0] q);
        cpu_access(1'b1, a, 32'h0, q);
    endtask

    task automatic start_dma(input logic [31:0] cntr, input int n, input int chip_n);
        cpu_write(sdmac_regs_pkg::REG_CNTR, cntr);
        cpu_write(sdmac_regs_pkg::REG_WTC, 32'(n));
        sent_bytes.delete();
        strobes = 0;
        chip_count = chip_n;
        cpu_write(sdmac_regs_pkg::REG_ST_DMA, 32'h0);
    endtask

    // Chip done first, then poll ISTR for the done flag
    task automatic wait_done();
        logic [31:0] st;
        int n;
        wait (chip_count == 0);
        n = 0;
        st = '0;
        while (!st[sdmac_regs_pkg::ISTR_DONE] && n < 10) begin
            cpu_read(sdmac_regs_pkg::REG_ISTR, st);
            n++;
        end
        if (!st[sdmac_regs_pkg::ISTR_DONE])
            fail("DMA never reported done");
    endtask

    task automatic read_words(input int first, input int cnt, input logic [31:0] w[$]);
        logic [31:0] q;
        for (int i = first; i < first + cnt; i++) begin
            cpu_read(sdmac_regs_pkg::REG_FIFO, q);
            check_word(q, w[i], $sformatf("FIFO word %0d", i));
        end
    endtask

    // SCSI chip: one byte per strobe, new read byte when IOR rises
    always @(posedge sclk_i) begin
        #1;
        if ((ior_o || iow_o) && !strobe_q) begin
            if (ior_o) begin
                xs = xorshift(xs);
                pd_i = xs[7:0];
                sent_bytes.push_back(xs[7:0]);
            end
            if (chip_count > 0)
                chip_count--;
            strobes++;
        end
        strobe_q = ior_o || iow_o;
        dreq_i = (chip_count > 0);
    end

    // Write bytes and interrupt level compared mid-cycle
    always @(negedge sclk_i) begin
        if (iow_o && !iow_prev) begin
            if (exp_bytes.size() == 0)
                fail("write strobe with no byte expected");
            check_byte(pd_o, exp_bytes.pop_front(), "port write byte");
            captured++;
        end
        iow_prev = iow_o;
        if (watch_int && int_o)
            fail("interrupt raised while disabled");
    end

    initial begin
        #WATCHDOG_NS;
        $display("watchdog expired before the tests finished");
        $display("Simulation failed");
        $fatal(1);
    end

    initial begin
        logic [31:0] q;
        logic [31:0] w[$];
        sdmac_regs_pkg::cntr_u c;
        rst_i = 1'b1;
        cs_i = 1'b0;
        as_i = 1'b0;
        rw_i = 1'b1;
        addr_i = '0;
        data_i = '0;
        repeat (2) @(posedge sclk_i);
        #1;
        rst_i = 1'b0;

        // Register readback
        cpu_read(sdmac_regs_pkg::REG_ISTR, q);
        check_word(q, 32'(1) << sdmac_regs_pkg::ISTR_FE, "ISTR after reset");
        c.raw = 32'h1234_5672;
        cpu_write(sdmac_regs_pkg::REG_CNTR, c.raw);
        cpu_read(sdmac_regs_pkg::REG_CNTR, q);
        check_cntr(q, c, "CNTR readback");
        cpu_write(sdmac_regs_pkg::REG_WTC, 32'h0012_3456);
        cpu_read(sdmac_regs_pkg::REG_WTC, q);
        check_word(q, 32'h0012_3456, "WTC readback");

        // Read DMA, last word padded
        start_dma(32'h2, 10, 10);
        wait_done();
        pack_ref(sent_bytes, w);
        read_words(0, 2, w);
        cpu_read(sdmac_regs_pkg::REG_FIFO, q);
        check_word(q, w[2], "FIFO word 2");
        check_word(32'(q[15:0]), 32'h0, "padding of last word");
        cpu_read(sdmac_regs_pkg::REG_WTC, q);
        check_word(q, 32'h0, "WTC after read DMA");

        // Write DMA of two longwords
        exp_bytes = '{8'hde, 8'had, 8'hbe, 8'hef, 8'h01, 8'h23, 8'h45, 8'h67};
        captured = 0;
        start_dma(32'h0, 8, 8);
        cpu_write(sdmac_regs_pkg::REG_FIFO, 32'hdead_beef);
        cpu_write(sdmac_regs_pkg::REG_FIFO, 32'h0123_4567);
        wait_done();
        check_word(32'(captured), 32'd8, "bytes written to port");

        // Back-pressure with a full FIFO
        start_dma(32'h2, 20, 20);
        wait (strobes == 16);
        repeat (40) @(posedge sclk_i);
        #1;
        check_word(32'(strobes), 32'd16, "strobes while FIFO full");
        // Popping frees space for the last four bytes
        pack_ref(sent_bytes, w);
        read_words(0, 4, w);
        wait_done();
        check_word(32'(sent_bytes.size()), 32'd20, "bytes after back-pressure");
        pack_ref(sent_bytes, w);
        read_words(4, 1, w);

        // Interrupt enabled, then cleared by CINT
        start_dma(32'h6, 4, 4);
        wait_done();
        check_word(32'(int_o), 32'd1, "int_o after done");
        cpu_write(sdmac_regs_pkg::REG_CINT, 32'h0);
        check_word(32'(int_o), 32'd0, "int_o after CINT");

        // Interrupt disabled for a whole DMA
        watch_int = 1'b1;
        start_dma(32'h2, 4, 4);
        wait_done();
        watch_int = 1'b0;

        // Stopped DMA leaves done clear
        start_dma(32'h2, 8, 0);
        cpu_write(sdmac_regs_pkg::REG_SP_DMA, 32'h0);
        cpu_read(sdmac_regs_pkg::REG_ISTR, q);
        check_word(32'(q[sdmac_regs_pkg::ISTR_DONE]), 32'd0, "ISTR done after stop");

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* resdmac.f */
rtl/sdmac_regs_pkg.sv
rtl/sdmac_port_pkg.sv
rtl/sdmac_registers.sv
rtl/scsi_port_sm.sv
rtl/dma_fifo.sv
rtl/resdmac.sv
tb/resdmac_asserts.sv
tb/resdmac_tb.sv

/* Makefile */
SRCS := $(wildcard rtl/*.sv tb/*.sv)

.PHONY: run clean

obj_dir/Vresdmac_tb: resdmac.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module resdmac_tb -f resdmac.f

run: obj_dir/Vresdmac_tb
	./obj_dir/Vresdmac_tb | tee /dev/stderr | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
